// ==== rtl/alu_pkg.sv ====
package alu_pkg;

    // q6.10 datapath widths
    localparam int DATA_W = 16;
    // fraction bits, used when the mac result is scaled back
    localparam int FRAC_W = 10;

    // one signed q6.10 value
    typedef logic signed [DATA_W-1:0] data_t;

    // saturation limits for 16-bit results
    localparam data_t DATA_MAX = {1'b0, {(DATA_W-1){1'b1}}};
    localparam data_t DATA_MIN = {1'b1, {(DATA_W-1){1'b0}}};

    // instruction codes
    // gaps at 3, 5, 8..14 are unused codes and return zero
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_MAC  = 4'd2,
        OP_GRAY = 4'd4,
        OP_ROT  = 4'd6,
        OP_CLZ  = 4'd7,
        OP_NOP  = 4'd15
    } alu_op_e;

    // request from issue stage to a unit
    // 4 + 16 + 16 bits
    typedef struct packed {
        alu_op_e op;
        data_t   a;
        data_t   b;
    } alu_req_t;

    // result from a unit to the merger
    // valid is a one-cycle pulse
    typedef struct packed {
        logic  valid;
        data_t data;
    } unit_res_t;

endpackage

// ==== rtl/alu_issue.sv ====
`timescale 1ns/1ps

module alu_issue
    import alu_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_in_valid,
    input  alu_op_e  i_inst,
    input  data_t    i_data_a,
    input  data_t    i_data_b,
    input  logic     i_bit_done,
    output logic     o_busy,
    output logic     o_arith_start,
    output alu_req_t o_arith_req,
    output logic     o_bit_start,
    output alu_req_t o_bit_req
);

    logic accept;
    // class of the incoming opcode
    logic to_bit;
    logic multi_cycle;

    // inputs are ignored while busy
    assign accept = i_in_valid && !o_busy;

    // decode once here, the units trust the class
    always_comb begin
        to_bit      = 1'b0;
        multi_cycle = 1'b0;
        case (i_inst)
            OP_GRAY: begin
                to_bit = 1'b1;
            end
            OP_ROT, OP_CLZ: begin
                to_bit      = 1'b1;
                multi_cycle = 1'b1;
            end
            // add, sub, mac, nop and unused codes
            default: begin
                to_bit = 1'b0;
            end
        endcase
    end

    // start pulses and busy
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_busy        <= 1'b0;
            o_arith_start <= 1'b0;
            o_bit_start   <= 1'b0;
        end else begin
            o_arith_start <= accept && !to_bit;
            o_bit_start   <= accept && to_bit;
            // done only arrives while busy, so no accept can collide
            if (i_bit_done) begin
                o_busy <= 1'b0;
            end else if (accept && multi_cycle) begin
                o_busy <= 1'b1;
            end
        end
    end

    // operand registers
    // each one only loads for its own unit, the other keeps its old value
    always_ff @(posedge i_clk) begin
        if (accept && !to_bit) begin
            o_arith_req <= '{op: i_inst, a: i_data_a, b: i_data_b};
        end
        if (accept && to_bit) begin
            o_bit_req <= '{op: i_inst, a: i_data_a, b: i_data_b};
        end
    end

endmodule

// ==== rtl/alu_arith_unit.sv ====
`timescale 1ns/1ps

module alu_arith_unit
    import alu_pkg::*;
#(
    // accumulator width, at least 2*DATA_W
    parameter int ACC_W = 36
) (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_start,
    input  alu_req_t  i_req,
    output unit_res_t o_res
);

    localparam int PROD_W = 2 * DATA_W;
    // rounded magnitude keeps one extra bit for the carry
    localparam int RND_W  = ACC_W - FRAC_W + 1;
    localparam logic signed [ACC_W-1:0] ACC_MAX = {1'b0, {(ACC_W-1){1'b1}}};
    localparam logic signed [ACC_W-1:0] ACC_MIN = {1'b1, {(ACC_W-1){1'b0}}};

    // add and sub
    logic signed [DATA_W:0]   add_b;
    logic signed [DATA_W:0]   add_sum;
    logic                     add_ovf;
    data_t                    add_res;
    // mac
    logic signed [PROD_W-1:0] prod;
    logic signed [ACC_W-1:0]  prod_ext;
    logic signed [ACC_W:0]    acc_sum;
    logic                     acc_ovf;
    logic signed [ACC_W-1:0]  acc_next;
    logic                     acc_neg;
    logic        [ACC_W-1:0]  acc_mag;
    logic        [RND_W-1:0]  mac_rnd;
    logic                     mac_sat;
    data_t                    mac_res;
    // state
    logic signed [ACC_W-1:0]  acc_q;
    logic                     res_valid_q;
    data_t                    res_data_q;

    // 17-bit sum, b negated for sub
    // -(-32768) fits in 17 bits
    assign add_b   = (i_req.op == OP_SUB) ? -{i_req.b[DATA_W-1], i_req.b}
                                          : {i_req.b[DATA_W-1], i_req.b};
    assign add_sum = {i_req.a[DATA_W-1], i_req.a} + add_b;
    assign add_ovf = add_sum[DATA_W] ^ add_sum[DATA_W-1];
    // overflow direction follows the sign of a
    assign add_res = add_ovf ? (i_req.a[DATA_W-1] ? DATA_MIN : DATA_MAX)
                             : add_sum[DATA_W-1:0];

    // exact q12.20 product
    assign prod     = $signed(i_req.a) * $signed(i_req.b);
    // sign extension to accumulator width
    assign prod_ext = prod;

    assign acc_sum  = {acc_q[ACC_W-1], acc_q} + {prod_ext[ACC_W-1], prod_ext};
    assign acc_ovf  = acc_sum[ACC_W] ^ acc_sum[ACC_W-1];
    assign acc_next = acc_ovf ? (acc_q[ACC_W-1] ? ACC_MIN : ACC_MAX)
                              : acc_sum[ACC_W-1:0];

    // magnitude, then back to q6.10
    // -ACC_MIN wraps to 2^(ACC_W-1), which is right as unsigned
    assign acc_neg = acc_next[ACC_W-1];
    assign acc_mag = acc_neg ? -acc_next : acc_next;
    // round half up on the highest dropped bit
    assign mac_rnd = {1'b0, acc_mag[ACC_W-1:FRAC_W]} + RND_W'(acc_mag[FRAC_W-1]);
    // anything at or above bit 15 no longer fits
    assign mac_sat = |mac_rnd[RND_W-1:DATA_W-1];
    assign mac_res = mac_sat ? (acc_neg ? DATA_MIN : DATA_MAX)
                             : (acc_neg ? data_t'(-mac_rnd[DATA_W-1:0])
                                        : data_t'(mac_rnd[DATA_W-1:0]));

    // accumulator and result valid
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            acc_q       <= '0;
            res_valid_q <= 1'b0;
        end else begin
            // every start gives exactly one result
            res_valid_q <= i_start;
            if (i_start && i_req.op == OP_MAC) begin
                acc_q <= acc_next;
            end
        end
    end

    // result data
    always_ff @(posedge i_clk) begin
        if (i_start) begin
            case (i_req.op)
                OP_ADD, OP_SUB: begin
                    res_data_q <= add_res;
                end
                OP_MAC: begin
                    res_data_q <= mac_res;
                end
                // nop and unused codes return zero
                default: begin
                    res_data_q <= '0;
                end
            endcase
        end
    end

    assign o_res = '{valid: res_valid_q, data: res_data_q};

endmodule

// ==== rtl/alu_bit_unit.sv ====
`timescale 1ns/1ps

module alu_bit_unit
    import alu_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_start,
    input  alu_req_t  i_req,
    output unit_res_t o_res,
    output logic      o_done
);

    // wide enough for a shift amount or a bit position
    localparam int CNT_W = $clog2(DATA_W);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ROT,
        ST_CLZ
    } state_e;

    state_e           state_q;
    logic [CNT_W-1:0] cnt_q;
    // target shift for rot
    logic [CNT_W-1:0] lim_q;
    // rotates right for rot, shifts left for clz
    data_t            work_q;
    logic             res_valid_q;
    data_t            res_data_q;
    logic             work_zero;
    logic             rot_done;
    logic             clz_done;

    assign work_zero = (work_q == '0);
    // shift 0 finishes on the first step
    assign rot_done  = (state_q == ST_ROT) && (cnt_q == lim_q);
    // stop on a leading one, or right away for an all-zero operand
    assign clz_done  = (state_q == ST_CLZ) && (work_q[DATA_W-1] || work_zero);
    assign o_done    = rot_done || clz_done;

    // fsm, step counter, result valid
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q     <= ST_IDLE;
            cnt_q       <= '0;
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (i_start) begin
                        cnt_q <= '0;
                        case (i_req.op)
                            OP_ROT:  state_q     <= ST_ROT;
                            OP_CLZ:  state_q     <= ST_CLZ;
                            // gray finishes in the start cycle
                            OP_GRAY: res_valid_q <= 1'b1;
                            default: state_q     <= ST_IDLE;
                        endcase
                    end
                end
                ST_ROT, ST_CLZ: begin
                    if (o_done) begin
                        state_q     <= ST_IDLE;
                        res_valid_q <= 1'b1;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // working register and result data
    always_ff @(posedge i_clk) begin
        case (state_q)
            ST_IDLE: begin
                if (i_start) begin
                    work_q <= i_req.a;
                    lim_q  <= i_req.b[CNT_W-1:0];
                    if (i_req.op == OP_GRAY) begin
                        // logical shift, msb passes through
                        res_data_q <= i_req.a ^ (i_req.a >> 1);
                    end
                end
            end
            ST_ROT: begin
                if (rot_done) begin
                    res_data_q <= work_q;
                end else begin
                    work_q <= {work_q[0], work_q[DATA_W-1:1]};
                end
            end
            ST_CLZ: begin
                if (clz_done) begin
                    // zero operand counts all DATA_W bits
                    res_data_q <= work_zero ? data_t'(DATA_W) : data_t'(cnt_q);
                end else begin
                    work_q <= {work_q[DATA_W-2:0], 1'b0};
                end
            end
            default: begin
                work_q <= work_q;
            end
        endcase
    end

    assign o_res = '{valid: res_valid_q, data: res_data_q};

endmodule

// ==== rtl/alu_result_merge.sv ====
`timescale 1ns/1ps

module alu_result_merge
    import alu_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  unit_res_t i_arith_res,
    input  unit_res_t i_bit_res,
    output logic      o_out_valid,
    output data_t     o_data
);

    logic  any_valid;
    data_t sel_data;

    // units never report in the same cycle
    assign any_valid = i_arith_res.valid || i_bit_res.valid;
    assign sel_data  = i_arith_res.valid ? i_arith_res.data : i_bit_res.data;

    // one-cycle valid pulse
    // o_data holds its last value between results
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_out_valid <= 1'b0;
            o_data      <= '0;
        end else begin
            o_out_valid <= any_valid;
            if (any_valid) begin
                o_data <= sel_data;
            end
        end
    end

endmodule

// ==== rtl/alu_top.sv ====
`timescale 1ns/1ps

module alu_top
    import alu_pkg::*;
#(
    // mac accumulator width
    parameter int ACC_W = 36
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_in_valid,
    input  logic [3:0] i_inst,
    input  data_t      i_data_a,
    input  data_t      i_data_b,
    output logic       o_busy,
    output logic       o_out_valid,
    output data_t      o_data
);

    // issue stage to units
    logic      arith_start;
    alu_req_t  arith_req;
    logic      bit_start;
    alu_req_t  bit_req;
    // bit unit finished a multi-cycle op
    logic      bit_done;
    // unit results to merger
    unit_res_t arith_res;
    unit_res_t bit_res;

    // decode, operand capture, busy
    alu_issue u_issue (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_in_valid    (i_in_valid),
        .i_inst        (alu_op_e'(i_inst)),
        .i_data_a      (i_data_a),
        .i_data_b      (i_data_b),
        .i_bit_done    (bit_done),
        .o_busy        (o_busy),
        .o_arith_start (arith_start),
        .o_arith_req   (arith_req),
        .o_bit_start   (bit_start),
        .o_bit_req     (bit_req)
    );

    // add, sub, mac and unknown codes
    alu_arith_unit #(
        .ACC_W (ACC_W)
    ) u_arith (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (arith_start),
        .i_req   (arith_req),
        .o_res   (arith_res)
    );

    // gray, rot, clz
    alu_bit_unit u_bit (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (bit_start),
        .i_req   (bit_req),
        .o_res   (bit_res),
        .o_done  (bit_done)
    );

    // output register
    alu_result_merge u_merge (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_arith_res (arith_res),
        .i_bit_res   (bit_res),
        .o_out_valid (o_out_valid),
        .o_data      (o_data)
    );

endmodule

// ==== tb/tb_alu.sv ====
`timescale 1ns/1ps

module tb_alu
    import alu_pkg::*;
();

    localparam int     WAIT_LIMIT = 200;
    // 36-bit accumulator limits
    localparam longint ACC_HI = 64'sh7_FFFF_FFFF;
    localparam longint ACC_LO = -64'sh8_0000_0000;

    // one expected result in accept order
    typedef struct packed {
        logic [3:0]  op;
        logic [15:0] data;
        logic        multi;
        logic [31:0] acc_cyc;
    } exp_item_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        in_valid;
    logic [3:0]  inst;
    data_t       data_a;
    data_t       data_b;
    logic        busy;
    logic        out_valid;
    data_t       data_out;

    exp_item_t   exp_q[$];
    // accept decided at the last falling edge
    exp_item_t   pend;
    logic        pend_valid;
    longint      model_acc = 0;
    int unsigned cyc = 0;
    int          n_issued = 0;
    int          n_done = 0;
    int          data_errs = 0;
    int          lat_errs = 0;
    int          busy_errs = 0;
    int          extra_errs = 0;
    int          rst_errs = 0;
    int          timeouts = 0;
    // monitor results held from one falling edge to the next
    logic        mon_chk = 1'b0;
    logic        mon_extra = 1'b0;
    logic        mon_lat_ok = 1'b1;
    logic        mon_busy_ok = 1'b1;
    logic        mon_rst_chk = 1'b0;
    logic        mon_rst_ok = 1'b1;
    logic [3:0]  mon_op;
    data_t       mon_got;
    data_t       mon_exp;
    // busy history of the rot or clz in flight
    logic        mc_first_busy = 1'b0;
    int          mc_low_cnt = 0;

    always #4 clk = ~clk;

    // rising edges seen so far
    always @(posedge clk) cyc <= cyc + 1;

    alu_top #(
        .ACC_W (36)
    ) UUT (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_in_valid  (in_valid),
        .i_inst      (inst),
        .i_data_a    (data_a),
        .i_data_b    (data_b),
        .o_busy      (busy),
        .o_out_valid (out_valid),
        .o_data      (data_out)
    );

    function automatic logic [15:0] rnd16();
        return 16'($urandom);
    endfunction

    // reference model with its own mac accumulator
    function automatic logic [15:0] model_result(input logic [3:0] op, input logic [15:0] a,
                                                 input logic [15:0] b);
        int          sa;
        int          sb;
        int          s;
        longint      sum;
        longint      mag;
        longint      rnd;
        logic [31:0] dbl;
        logic [15:0] r;
        sa = $signed(a);
        sb = $signed(b);
        r  = '0;
        case (op)
            OP_ADD, OP_SUB: begin
                s = (op == OP_ADD) ? sa + sb : sa - sb;
                s = (s > 32767) ? 32767 : ((s < -32768) ? -32768 : s);
                r = 16'(s);
            end
            OP_MAC: begin
                sum = model_acc + longint'(sa) * longint'(sb);
                sum = (sum > ACC_HI) ? ACC_HI : ((sum < ACC_LO) ? ACC_LO : sum);
                model_acc = sum;
                mag = (sum < 0) ? -sum : sum;
                // drop 10 fraction bits and round half up on bit 9
                rnd = (mag >>> 10) + longint'(mag[9]);
                if (rnd > 32767) begin
                    r = (sum < 0) ? 16'h8000 : 16'h7fff;
                end else begin
                    r = (sum < 0) ? 16'(-rnd) : 16'(rnd);
                end
            end
            OP_GRAY: r = a ^ (a >> 1);
            OP_ROT: begin
                dbl = {a, a} >> b[3:0];
                r   = dbl[15:0];
            end
            OP_CLZ: begin
                r = 16'd16;
                for (int i = 0; i < 16; i++) begin
                    if (a[15 - i] && r == 16'd16) begin
                        r = 16'(i);
                    end
                end
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    // pops at the falling edge where a result shows
    always @(negedge clk) begin
        exp_item_t item;
        mon_chk     <= 1'b0;
        mon_rst_chk <= !rst_n;
        mon_rst_ok  <= !busy && !out_valid && (data_out == '0);
        if (out_valid) begin
            mon_chk <= 1'b1;
            mon_got <= data_out;
            mon_extra <= (exp_q.size() == 0);
            if (exp_q.size() != 0) begin
                item = exp_q.pop_front();
                mon_op      <= item.op;
                mon_exp     <= item.data;
                // single-cycle ops come out two edges after accept
                mon_lat_ok  <= item.multi || (cyc == item.acc_cyc + 2);
                // busy held after accept and low for one cycle before the result
                mon_busy_ok <= !item.multi || (mc_first_busy && mc_low_cnt == 1);
                n_done      <= n_done + 1;
            end
        end else if (!busy) begin
            mc_low_cnt = mc_low_cnt + 1;
        end
        // first falling edge after the accept edge
        if (pend_valid) begin
            exp_q.push_back(pend);
            if (pend.multi) begin
                mc_first_busy = busy;
                mc_low_cnt    = 0;
            end
        end
    end

    a_value: assert property (@(posedge clk) (mon_chk && !mon_extra) |-> (mon_got == mon_exp))
        else begin
            data_errs++;
            $display("** Error @ %0t ns: op %0d gave %h, expected %h",
                     $time, mon_op, mon_got, mon_exp);
        end

    a_latency: assert property (@(posedge clk) (mon_chk && !mon_extra) |-> mon_lat_ok)
        else begin
            lat_errs++;
            $display("result of op %0d came out on the wrong cycle at %0t ns", mon_op, $time);
        end

    a_busy: assert property (@(posedge clk) (mon_chk && !mon_extra) |-> mon_busy_ok)
        else begin
            busy_errs++;
            $display("busy did not cover op %0d up to its result at %0t ns", mon_op, $time);
        end

    a_extra: assert property (@(posedge clk) mon_chk |-> !mon_extra)
        else begin
            extra_errs++;
            $display("a result came out with nothing outstanding at %0t ns", $time);
        end

    a_reset: assert property (@(posedge clk) mon_rst_chk |-> mon_rst_ok)
        else begin
            rst_errs++;
            $display("** Error @ %0t ns: outputs not zero during reset", $time);
        end

    task automatic finish_run();
        int total;
        total = data_errs + lat_errs + busy_errs + extra_errs + rst_errs + timeouts;
        $display("results %0d errs: data %0d lat %0d busy %0d extra %0d rst %0d timeout %0d",
                 n_done, data_errs, lat_errs, busy_errs, extra_errs, rst_errs, timeouts);
        if (total == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    // offers junk while busy and then drives one instruction
    task automatic issue(input logic [3:0] op, input logic [15:0] a, input logic [15:0] b);
        int waited;
        waited = 0;
        @(negedge clk);
        while (busy && waited < WAIT_LIMIT) begin
            in_valid   <= 1'b1;
            inst       <= 4'($urandom);
            data_a     <= rnd16();
            data_b     <= rnd16();
            pend_valid <= 1'b0;
            waited++;
            @(negedge clk);
        end
        if (busy) begin
            timeouts++;
            $display("timeout: DUT stayed busy for %0d cycles", WAIT_LIMIT);
            finish_run();
        end else begin
            in_valid   <= 1'b1;
            inst       <= op;
            data_a     <= a;
            data_b     <= b;
            pend       <= '{op: op, data: model_result(op, a, b),
                            multi: (op == OP_ROT || op == OP_CLZ), acc_cyc: cyc + 1};
            pend_valid <= 1'b1;
            n_issued++;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(negedge clk);
        in_valid   <= 1'b0;
        pend_valid <= 1'b0;
        while (n_done != n_issued && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (n_done != n_issued) begin
            timeouts++;
            $display("timeout: %0d results never came out", n_issued - n_done);
            finish_run();
        end
    endtask

    initial begin
        logic [15:0] a;
        logic [15:0] b;
        void'($urandom(32'h1bd2c303));
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        inst       = 4'd0;
        data_a     = '0;
        data_b     = '0;
        pend_valid = 1'b0;
        pend       = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n <= 1'b1;
        // back to back add and sub that saturate both ways
        issue(OP_ADD, 16'h7000, 16'h2000);
        issue(OP_ADD, 16'h9000, 16'h9000);
        issue(OP_SUB, 16'h7000, 16'h9000);
        issue(OP_SUB, 16'h9000, 16'h7000);
        issue(OP_SUB, 16'h0000, 16'h8000);
        for (int i = 0; i < 40; i++) begin
            issue(4'(i % 2), rnd16(), rnd16());
        end
        // small mac operands keep rounding on bit 9 visible
        for (int i = 0; i < 20; i++) begin
            a = rnd16();
            b = rnd16();
            issue(OP_MAC, {{6{a[9]}}, a[9:0]}, {{6{b[9]}}, b[9:0]});
        end
        for (int i = 0; i < 20; i++) begin
            issue(OP_MAC, rnd16(), rnd16());
        end
        // pile up to the positive limit and down to the negative one
        for (int i = 0; i < 40; i++) begin
            issue(OP_MAC, 16'h8000, 16'h8000);
        end
        for (int i = 0; i < 80; i++) begin
            issue(OP_MAC, 16'h8000, 16'h7fff);
        end
        // gray and unused codes including nop
        issue(4'd3, rnd16(), rnd16());
        issue(4'd5, rnd16(), rnd16());
        for (int i = 0; i < 30; i++) begin
            issue(OP_GRAY, rnd16(), rnd16());
            issue(4'(8 + (i % 8)), rnd16(), rnd16());
        end
        for (int i = 0; i < 30; i++) begin
            b = rnd16();
            if (i % 4 == 0) begin
                b[3:0] = 4'd0;
            end
            issue(OP_ROT, rnd16(), b);
        end
        // clz on zero and single bits and then varied leading zeros
        issue(OP_CLZ, 16'h0000, rnd16());
        for (int i = 0; i < 16; i++) begin
            issue(OP_CLZ, 16'h0001 << i, rnd16());
        end
        for (int i = 0; i < 20; i++) begin
            issue(OP_CLZ, rnd16() >> (i % 16), rnd16());
        end
        // everything mixed
        for (int i = 0; i < 60; i++) begin
            issue(4'($urandom), rnd16(), rnd16());
        end
        drain();
        repeat (4) @(negedge clk);
        finish_run();
    end

endmodule

// ==== compile.f ====
rtl/alu_pkg.sv
rtl/alu_issue.sv
rtl/alu_arith_unit.sv
rtl/alu_bit_unit.sv
rtl/alu_result_merge.sv
rtl/alu_top.sv
tb/tb_alu.sv

// ==== Makefile ====
# Verilator build and run of the ALU testbench

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_alu -f compile.f -o tb_alu
	@out="$$(./obj_dir/tb_alu)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

lint:
	verilator --lint-only -Wall --timing --assert --top-module tb_alu -f compile.f

clean:
	rm -rf obj_dir
